// File: src/crypto_fu_pkg.sv
/*
 * Shared opcode and unit-select types plus width constants for the scalar
 * crypto functional unit. Modules import this inside their body.
 */
package crypto_fu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    parameter int sha_word_w   = 32;    // SHA-256 and SM3 word width
    parameter int xlen_default = 32;    // Default XLEN, 32 or 64

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        op_xperm4      = 4'd0,          // Nibble crossbar
        op_xperm8      = 4'd1,          // Byte crossbar
        op_sha256_sig0 = 4'd2,          // SHA-256 small sigma 0
        op_sha256_sig1 = 4'd3,          // SHA-256 small sigma 1
        op_sha256_sum0 = 4'd4,          // SHA-256 big sigma 0
        op_sha256_sum1 = 4'd5,          // SHA-256 big sigma 1
        op_sm3_p0      = 4'd6,          // SM3 P0 permutation
        op_sm3_p1      = 4'd7           // SM3 P1 permutation
    } crypto_op_e;

    // Execution unit that owns an opcode
    typedef enum logic [1:0] {
        unit_xperm  = 2'd0,             // Crossbar permutation
        unit_sha256 = 2'd1,             // SHA-256 sigma/sum
        unit_sm3    = 2'd2              // SM3 permutations
    } unit_sel_e;

endpackage

// File: src/crypto_fu_issue.sv
/*
 * Issue stage. Accepts one request while idle, registers the operands and
 * fires a single start pulse at the unit that owns the opcode.
 */
`timescale 1ns/10ps

module crypto_fu_issue #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      valid,              // Request present
    input  crypto_fu_pkg::crypto_op_e op,
    input  logic [XLEN-1:0]           rs1,
    input  logic [XLEN-1:0]           rs2,
    input  logic                      retire,             // Result left the arbiter
    output logic                      xperm_start,
    output logic                      sha_start,
    output logic                      sm3_start,
    output crypto_fu_pkg::crypto_op_e op_q,               // Captured at accept
    output logic [XLEN-1:0]           rs1_q,
    output logic [XLEN-1:0]           rs2_q
);
    import crypto_fu_pkg::*;

    logic      busy;                    // One item in flight
    logic      accept;                  // Take the request this edge
    unit_sel_e sel;                     // Decoded target unit

    assign accept = valid && !busy;     // Held valid ignored while busy

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------
    always_comb begin
        case (op)
            op_xperm4, op_xperm8:         sel = unit_xperm;
            op_sha256_sig0, op_sha256_sig1,
            op_sha256_sum0, op_sha256_sum1: sel = unit_sha256;
            op_sm3_p0, op_sm3_p1:         sel = unit_sm3;
            default:                      sel = unit_xperm;  // Unused codes still complete
        endcase
    end

    // --------------------------------------------------
    // Busy flag and start pulses
    // --------------------------------------------------
    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            busy        <= 1'b0;
            xperm_start <= 1'b0;
            sha_start   <= 1'b0;
            sm3_start   <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (retire) begin
                busy <= 1'b0;           // Free on the ready cycle's edge
            end
            xperm_start <= accept && (sel == unit_xperm);
            sha_start   <= accept && (sel == unit_sha256);
            sm3_start   <= accept && (sel == unit_sm3);
        end
    end

    // Operand capture
    always_ff @(posedge dut_g_clk) begin
        if (accept) begin
            op_q  <= op;
            rs1_q <= rs1;
            rs2_q <= rs2;
        end
    end

    // Only one unit may be started per request
    a_start_onehot : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        $onehot0({xperm_start, sha_start, sm3_start}));

    // Every start comes back as a retire two cycles later
    a_start_retire : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        (xperm_start || sha_start || sm3_start) |-> ##2 retire);

endmodule

// File: src/xperm_unit.sv
/*
 * Crossbar permutation unit for xperm4 and xperm8. Each rs2 element picks
 * an rs1 element; out of range indices give zero. Result is registered.
 */
`timescale 1ns/10ps

module xperm_unit #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      start,               // One-cycle kick
    input  crypto_fu_pkg::crypto_op_e op_q,
    input  logic [XLEN-1:0]           rs1_q,               // Lookup table
    input  logic [XLEN-1:0]           rs2_q,               // Index vector
    output logic                      done,
    output logic [XLEN-1:0]           xperm_res
);
    import crypto_fu_pkg::*;

    localparam int n_nibbles = XLEN / 4;    // 8 or 16 elements
    localparam int n_bytes   = XLEN / 8;    // 4 or 8 elements

    logic [XLEN-1:0] perm4;             // Nibble crossbar
    logic [XLEN-1:0] perm8;             // Byte crossbar

    // --------------------------------------------------
    // Nibble lookup
    // --------------------------------------------------
    always_comb begin
        int unsigned idx;
        perm4 = '0;
        for (int i = 0; i < n_nibbles; i++) begin
            idx = rs2_q[4*i +: 4];
            if (idx < n_nibbles) begin
                perm4[4*i +: 4] = rs1_q[4*idx +: 4];
            end
        end
    end

    // --------------------------------------------------
    // Byte lookup
    // --------------------------------------------------
    always_comb begin
        int unsigned idx;
        perm8 = '0;
        for (int i = 0; i < n_bytes; i++) begin
            idx = rs2_q[8*i +: 8];
            if (idx < n_bytes) begin
                perm8[8*i +: 8] = rs1_q[8*idx +: 8];
            end
        end
    end

    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;              // Fixed one-cycle latency
        end
    end

    always_ff @(posedge dut_g_clk) begin
        if (start) begin
            xperm_res <= (op_q == op_xperm8) ? perm8 : perm4;
        end
    end

endmodule

// File: src/sha256_sigma_unit.sv
/*
 * SHA-256 sigma0/sigma1/sum0/sum1 on the low word of rs1, sign-extended
 * to XLEN and registered one cycle after start.
 */
`timescale 1ns/10ps

module sha256_sigma_unit #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      start,
    input  crypto_fu_pkg::crypto_op_e op_q,
    input  logic [XLEN-1:0]           rs1_q,
    output logic                      done,
    output logic [XLEN-1:0]           sha_res
);
    import crypto_fu_pkg::*;

    // Rotate and shift amounts from FIPS 180-4
    localparam int sig0_r1 = 7;
    localparam int sig0_r2 = 18;
    localparam int sig0_sh = 3;
    localparam int sig1_r1 = 17;
    localparam int sig1_r2 = 19;
    localparam int sig1_sh = 10;
    localparam int sum0_r1 = 2;
    localparam int sum0_r2 = 13;
    localparam int sum0_r3 = 22;
    localparam int sum1_r1 = 6;
    localparam int sum1_r2 = 11;
    localparam int sum1_r3 = 25;

    logic [sha_word_w-1:0] word;        // Low word of rs1
    logic [sha_word_w-1:0] fn_out;      // Selected function

    function automatic logic [sha_word_w-1:0] rotr(input logic [sha_word_w-1:0] x,
                                                   input int n);
        rotr = (x >> n) | (x << (sha_word_w - n));
    endfunction

    assign word = rs1_q[sha_word_w-1:0];

    always_comb begin
        case (op_q)
            op_sha256_sig0: fn_out = rotr(word, sig0_r1) ^ rotr(word, sig0_r2) ^ (word >> sig0_sh);
            op_sha256_sig1: fn_out = rotr(word, sig1_r1) ^ rotr(word, sig1_r2) ^ (word >> sig1_sh);
            op_sha256_sum0: fn_out = rotr(word, sum0_r1) ^ rotr(word, sum0_r2) ^ rotr(word, sum0_r3);
            op_sha256_sum1: fn_out = rotr(word, sum1_r1) ^ rotr(word, sum1_r2) ^ rotr(word, sum1_r3);
            default:        fn_out = '0;    // Not a SHA-256 op
        endcase
    end

    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge dut_g_clk) begin
        if (start) begin
            sha_res <= XLEN'($signed(fn_out));  // Sign-extend for RV64
        end
    end

endmodule

// File: src/sm3_perm_unit.sv
/*
 * SM3 P0 and P1 permutations on the low word of rs1, sign-extended to
 * XLEN and registered one cycle after start.
 */
`timescale 1ns/10ps

module sm3_perm_unit #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      start,
    input  crypto_fu_pkg::crypto_op_e op_q,
    input  logic [XLEN-1:0]           rs1_q,
    output logic                      done,
    output logic [XLEN-1:0]           sm3_res
);
    import crypto_fu_pkg::*;

    localparam int p0_r1 = 9;           // P0 left rotations
    localparam int p0_r2 = 17;
    localparam int p1_r1 = 15;          // P1 left rotations
    localparam int p1_r2 = 23;

    logic [sha_word_w-1:0] word;
    logic [sha_word_w-1:0] p0;
    logic [sha_word_w-1:0] p1;

    function automatic logic [sha_word_w-1:0] rotl(input logic [sha_word_w-1:0] x,
                                                   input int n);
        rotl = (x << n) | (x >> (sha_word_w - n));
    endfunction

    assign word = rs1_q[sha_word_w-1:0];
    assign p0   = word ^ rotl(word, p0_r1) ^ rotl(word, p0_r2);
    assign p1   = word ^ rotl(word, p1_r1) ^ rotl(word, p1_r2);

    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge dut_g_clk) begin
        if (start) begin
            sm3_res <= XLEN'($signed((op_q == op_sm3_p1) ? p1 : p0));  // P0 otherwise
        end
    end

endmodule

// File: src/result_arbiter.sv
/*
 * Result bus arbiter. Grants rd to the unit that finished, fixed priority
 * xperm > sha256 > sm3, and raises a one-cycle ready with retire.
 */
`timescale 1ns/10ps

module result_arbiter #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic            dut_g_clk,
    input  logic            dut_g_resetn,
    input  logic            xperm_done,
    input  logic            sha_done,
    input  logic            sm3_done,
    input  logic [XLEN-1:0] xperm_res,
    input  logic [XLEN-1:0] sha_res,
    input  logic [XLEN-1:0] sm3_res,
    output logic [XLEN-1:0] rd,         // Held until next grant
    output logic            ready,      // One-cycle result strobe
    output logic            retire      // Back to issue, frees busy
);
    import crypto_fu_pkg::*;

    unit_sel_e       grant_sel;         // Winning unit
    logic            grant_any;         // Some unit finished
    logic [XLEN-1:0] grant_res;

    // --------------------------------------------------
    // Fixed priority grant
    // --------------------------------------------------
    always_comb begin
        grant_any = xperm_done | sha_done | sm3_done;
        if (xperm_done) begin
            grant_sel = unit_xperm;
        end else if (sha_done) begin
            grant_sel = unit_sha256;
        end else begin
            grant_sel = unit_sm3;
        end
    end

    always_comb begin
        case (grant_sel)
            unit_xperm:  grant_res = xperm_res;
            unit_sha256: grant_res = sha_res;
            default:     grant_res = sm3_res;
        endcase
    end

    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            rd    <= '0;
            ready <= 1'b0;
        end else begin
            ready <= grant_any;
            if (grant_any) begin
                rd <= grant_res;
            end
        end
    end

    assign retire = ready;              // Same cycle as ready

    // Single item in flight, so finishers never collide
    a_done_onehot : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        $onehot0({xperm_done, sha_done, sm3_done}));

endmodule

// File: src/crypto_fu_top.sv
/*
 * Top level of the scalar crypto functional unit. Wires the issue stage,
 * the xperm, SHA-256 and SM3 units and the result arbiter.
 */
`timescale 1ns/10ps

module crypto_fu_top #(
    parameter int XLEN = crypto_fu_pkg::xlen_default    // 32 or 64
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      valid,           // Held until ready
    input  crypto_fu_pkg::crypto_op_e op,
    input  logic [XLEN-1:0]           rs1,
    input  logic [XLEN-1:0]           rs2,
    output logic                      ready,
    output logic [XLEN-1:0]           rd
);
    import crypto_fu_pkg::*;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    logic            xperm_start;
    logic            sha_start;
    logic            sm3_start;
    crypto_op_e      op_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic            xperm_done;
    logic            sha_done;
    logic            sm3_done;
    logic [XLEN-1:0] xperm_res;
    logic [XLEN-1:0] sha_res;
    logic [XLEN-1:0] sm3_res;
    logic            retire;

    crypto_fu_issue #(.XLEN(XLEN)) crypto_fu_issue_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .valid        (valid),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .retire       (retire),
        .xperm_start  (xperm_start),
        .sha_start    (sha_start),
        .sm3_start    (sm3_start),
        .op_q         (op_q),
        .rs1_q        (rs1_q),
        .rs2_q        (rs2_q)
    );

    xperm_unit #(.XLEN(XLEN)) xperm_unit_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .start        (xperm_start),
        .op_q         (op_q),
        .rs1_q        (rs1_q),
        .rs2_q        (rs2_q),
        .done         (xperm_done),
        .xperm_res    (xperm_res)
    );

    sha256_sigma_unit #(.XLEN(XLEN)) sha256_sigma_unit_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .start        (sha_start),
        .op_q         (op_q),
        .rs1_q        (rs1_q),
        .done         (sha_done),
        .sha_res      (sha_res)
    );

    sm3_perm_unit #(.XLEN(XLEN)) sm3_perm_unit_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .start        (sm3_start),
        .op_q         (op_q),
        .rs1_q        (rs1_q),
        .done         (sm3_done),
        .sm3_res      (sm3_res)
    );

    // Shared result bus
    result_arbiter #(.XLEN(XLEN)) result_arbiter_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .xperm_done   (xperm_done),
        .sha_done     (sha_done),
        .sm3_done     (sm3_done),
        .xperm_res    (xperm_res),
        .sha_res      (sha_res),
        .sm3_res      (sm3_res),
        .rd           (rd),
        .ready        (ready),
        .retire       (retire)
    );

endmodule

// File: testbench/crypto_fu_checker.sv
/*
 * Testbench checker. Watches the DUT ports on the falling edge and counts
 * wrong rd values, handshake timing faults and requests that never finish.
 */
`timescale 1ns/10ps

module crypto_fu_checker #(
    parameter int XLEN           = crypto_fu_pkg::xlen_default,
    parameter int timeout_cycles = 16                  // Give up on a request
) (
    input  logic                      dut_g_clk,
    input  logic                      dut_g_resetn,
    input  logic                      valid,
    input  crypto_fu_pkg::crypto_op_e op,
    input  logic [XLEN-1:0]           rs1,
    input  logic [XLEN-1:0]           rs2,
    input  logic                      ready,
    input  logic [XLEN-1:0]           rd,
    input  logic [XLEN-1:0]           exp_rd,            // Published by the driver
    output int                        value_errs,
    output int                        timing_errs,
    output int                        timeout_errs
);
    import crypto_fu_pkg::*;

    logic            pending;           // Request outstanding
    int              cycles;            // Rising edges since request seen
    crypto_op_e      op_seen;
    logic [XLEN-1:0] rs1_seen;
    logic [XLEN-1:0] rs2_seen;

    initial begin
        value_errs   = 0;
        timing_errs  = 0;
        timeout_errs = 0;
        pending      = 1'b0;
        cycles       = 0;
    end

    // --------------------------------------------------
    // Falling edge sampling, outputs settled
    // --------------------------------------------------
    always @(negedge dut_g_clk) begin
        if (dut_g_resetn) begin
            pending = 1'b0;             // Nothing counts in reset
        end else if (!pending) begin
            if (ready !== 1'b0) begin   // Also catches a stuck ready
                timing_errs++;
                $display("ready was high with no request outstanding at %0t", $time);
            end
            if (valid === 1'b1) begin
                pending  = 1'b1;
                cycles   = 0;
                op_seen  = op;
                rs1_seen = rs1;
                rs2_seen = rs2;
            end
        end else begin
            cycles++;
            if (valid !== 1'b1 || op !== op_seen || rs1 !== rs1_seen || rs2 !== rs2_seen) begin
                timing_errs++;
                $display("request changed before ready at %0t", $time);
            end
            if (ready === 1'b1) begin
                if (cycles != 3) begin  // Accept, start, done, ready
                    timing_errs++;
                    $display("ready came %0d cycles after the request instead of 3", cycles);
                end
                if (rd !== exp_rd) begin
                    value_errs++;
                    $display("mismatch rd: expected 0x%h actual 0x%h (op %0d)",
                             exp_rd, rd, op_seen);
                end
                pending = 1'b0;
            end else if (cycles >= timeout_cycles) begin
                timeout_errs++;
                $display("no ready within %0d cycles of the request", timeout_cycles);
                pending = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_crypto_fu.sv
/*
 * Testbench for the scalar crypto unit. Builds a table of requests with
 * expected results from reference functions, drives it through the valid
 * and ready handshake and reports the checker's error counts.
 */
`timescale 1ns/10ps

module tb_crypto_fu;
    import crypto_fu_pkg::*;

    localparam int XLEN          = xlen_default;
    localparam int clk_period    = 20;
    localparam int drive_delay   = 2;     // After the rising edge
    localparam int ready_timeout = 20;    // Cycles to wait for ready

    logic            dut_g_clk;
    logic            dut_g_resetn;
    logic            valid;
    crypto_op_e      op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            ready;
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] exp_rd;              // Current expected result
    int              value_errs;
    int              timing_errs;
    int              timeout_errs;
    int              wait_timeouts;       // Driver side timeouts
    int              seed;

    // Stimulus table columns
    crypto_op_e      op_tab[$];
    logic [XLEN-1:0] rs1_tab[$];
    logic [XLEN-1:0] rs2_tab[$];
    logic [XLEN-1:0] exp_tab[$];

    crypto_fu_top #(.XLEN(XLEN)) crypto_fu_top_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .valid        (valid),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .ready        (ready),
        .rd           (rd)
    );

    crypto_fu_checker #(.XLEN(XLEN)) crypto_fu_checker_inst (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .valid        (valid),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .ready        (ready),
        .rd           (rd),
        .exp_rd       (exp_rd),
        .value_errs   (value_errs),
        .timing_errs  (timing_errs),
        .timeout_errs (timeout_errs)
    );

    initial begin
        dut_g_clk = 1'b0;
        forever #(clk_period / 2) dut_g_clk = ~dut_g_clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
        logic [63:0] twice;
        twice = {x, x} >> n;              // Wrap by doubling the word
        return twice[31:0];
    endfunction

    function automatic logic [31:0] rotl32(input logic [31:0] x, input int n);
        return rotr32(x, (32 - n) % 32);
    endfunction

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] w);
        logic [XLEN-1:0] r;
        r       = {XLEN{w[31]}};
        r[31:0] = w;
        return r;
    endfunction

    // Element size sz is 4 or 8; index past the last element gives zero
    function automatic logic [XLEN-1:0] xperm_ref(input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b, input int sz);
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] mask;
        int              n;
        int              idx;
        n    = XLEN / sz;
        mask = XLEN'((1 << sz) - 1);
        r    = '0;
        for (int i = 0; i < n; i++) begin
            idx = int'((b >> (i * sz)) & mask);
            if (idx < n) begin
                r = r | (((a >> (idx * sz)) & mask) << (i * sz));
            end
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] expected_rd(input crypto_op_e o,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
        logic [31:0] w;
        w = a[31:0];
        case (o)
            op_xperm4:      return xperm_ref(a, b, 4);
            op_xperm8:      return xperm_ref(a, b, 8);
            op_sha256_sig0: return sext32(rotr32(w, 7) ^ rotr32(w, 18) ^ (w >> 3));
            op_sha256_sig1: return sext32(rotr32(w, 17) ^ rotr32(w, 19) ^ (w >> 10));
            op_sha256_sum0: return sext32(rotr32(w, 2) ^ rotr32(w, 13) ^ rotr32(w, 22));
            op_sha256_sum1: return sext32(rotr32(w, 6) ^ rotr32(w, 11) ^ rotr32(w, 25));
            op_sm3_p0:      return sext32(w ^ rotl32(w, 9) ^ rotl32(w, 17));
            op_sm3_p1:      return sext32(w ^ rotl32(w, 15) ^ rotl32(w, 23));
            default:        return '0;
        endcase
    endfunction

    // --------------------------------------------------
    // Table construction
    // --------------------------------------------------
    task automatic add_row(input crypto_op_e o, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        op_tab.push_back(o);
        rs1_tab.push_back(a);
        rs2_tab.push_back(b);
        exp_tab.push_back(expected_rd(o, a, b));
    endtask

    task automatic add_all_ops(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        for (int k = 0; k < 8; k++) begin
            add_row(crypto_op_e'(k), a, b);
        end
    endtask

    function automatic logic [XLEN-1:0] random_word();
        logic [63:0] both;
        both = {$random(seed), $random(seed)};
        return both[XLEN-1:0];
    endfunction

    task automatic build_table();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        add_all_ops(XLEN'(32'h01020304), XLEN'(32'h090a0b0c));
        if (XLEN == 64) begin
            add_all_ops(XLEN'(64'h0102030405060708), XLEN'(64'h090a0b0c0d0e0f00));
        end
        add_row(op_xperm4, XLEN'(64'hfedcba9876543210), XLEN'(32'h01234567));  // Reverse
        add_row(op_xperm8, XLEN'(64'h8877665544332211), XLEN'(32'h00010203));
        add_row(op_xperm8, XLEN'(64'h8877665544332211), XLEN'(32'h05000102));  // Mixed range
        for (int i = 0; i < 40; i++) begin
            a = random_word();
            b = random_word();
            if (i % 2 == 1) begin
                b = b & {(XLEN / 8){8'h07}};  // Pull indices mostly in range
            end
            add_row(crypto_op_e'($unsigned($random(seed)) % 8), a, b);
        end
    endtask

    // --------------------------------------------------
    // Drive loop
    // --------------------------------------------------
    task automatic run_table();
        int   cycles;
        logic seen;
        for (int i = 0; i < op_tab.size(); i++) begin
            @(posedge dut_g_clk);
            #drive_delay;
            valid  = 1'b1;              // Back to back after ready
            op     = op_tab[i];
            rs1    = rs1_tab[i];
            rs2    = rs2_tab[i];
            exp_rd = exp_tab[i];
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < ready_timeout) begin
                @(posedge dut_g_clk);
                #drive_delay;
                cycles++;
                seen = (ready === 1'b1);
            end
            if (!seen) begin
                wait_timeouts++;
                $display("ready never came for table row %0d", i);
                break;
            end
            if (i % 5 == 4) begin
                @(posedge dut_g_clk);
                #drive_delay;
                valid = 1'b0;           // One idle cycle now and then
            end
        end
    endtask

    initial begin
        int total;
        seed          = 3613;
        dut_g_resetn  = 1'b1;           // Reset asserted
        valid         = 1'b0;
        op            = op_xperm4;
        rs1           = '0;
        rs2           = '0;
        exp_rd        = '0;
        wait_timeouts = 0;
        build_table();
        repeat (3) @(posedge dut_g_clk);
        #drive_delay;
        dut_g_resetn = 1'b0;
        repeat (4) @(posedge dut_g_clk);  // Idle, ready must stay low
        run_table();
        @(posedge dut_g_clk);
        #drive_delay;
        valid = 1'b0;
        repeat (3) @(posedge dut_g_clk);
        total = value_errs + timing_errs + timeout_errs + wait_timeouts;
        $display("errors: value %0d timing %0d timeout %0d driver timeout %0d",
                 value_errs, timing_errs, timeout_errs, wait_timeouts);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
src/crypto_fu_pkg.sv
src/crypto_fu_issue.sv
src/xperm_unit.sv
src/sha256_sigma_unit.sv
src/sm3_perm_unit.sv
src/result_arbiter.sv
src/crypto_fu_top.sv
testbench/crypto_fu_checker.sv
testbench/tb_crypto_fu.sv

// File: Bender.yml
package:
  name: crypto_fu

sources:
  - src/crypto_fu_pkg.sv
  - src/crypto_fu_issue.sv
  - src/xperm_unit.sv
  - src/sha256_sigma_unit.sv
  - src/sm3_perm_unit.sv
  - src/result_arbiter.sv
  - src/crypto_fu_top.sv
  - target: test
    files:
      - testbench/crypto_fu_checker.sv
      - testbench/tb_crypto_fu.sv
